// File: source/rtc_consts.svh
/*
 * Fixed constants of the RTC counting pipeline.
 * Divider width for 32768 Hz, day-of-week limits and the field positions
 * inside the two DS3231-style configuration words. Include where needed.
 */
`ifndef RTC_CONSTS_SVH
`define RTC_CONSTS_SVH

//------------------------------
// Clock divider
//------------------------------
`define RTC_DIV_WIDTH      15   // 2^15 cycles of 32768 Hz = 1 s

//------------------------------
// Time word layout
//------------------------------
// Seconds field starts at bit 0
`define RTC_CFG_MIN_LSB    8    // Minutes byte
`define RTC_CFG_HOUR_LSB   16   // Hours byte, 24-hour only
`define RTC_CFG_DOW_LSB    24   // Day of week byte

//------------------------------
// Date word layout
//------------------------------
// Day field starts at bit 0
`define RTC_CFG_MONTH_LSB  8    // Month byte
`define RTC_CFG_YEAR_LSB   16   // Year byte
`define RTC_CFG_CENT_LSB   24   // Century byte

`define RTC_DOW_MAX        7    // Last day of week
`define RTC_DOW_MIN        1    // First day of week, also reset value

`endif

// File: source/rtc_pkg.sv
/*
 * Types shared by the RTC stages.
 * BCD digit widths and the 32-bit configuration word live here.
 */
`default_nettype none

package rtc_pkg;

	// Units digit, 0..9
	typedef logic [3:0] bcd_digit_t;

	// Tens of seconds or minutes, 0..5
	typedef logic [2:0] bcd_tens3_t;

	// Tens of hours or days, 0..3
	typedef logic [1:0] bcd_tens2_t;

	// Day of week, 1..7
	typedef logic [2:0] dow_t;

	// Packed BCD fields, one byte per field
	// Time word: sec, min, hour, dow
	// Date word: day, month, year, century
	typedef logic [31:0] cfg_word_t;

endpackage

`default_nettype wire

// File: source/rtc_tick_gen.sv
/*
 * Stage one of the RTC pipeline.
 * Divides the 32768 Hz clock into a one-cycle tick per second; fast mode
 * ticks every second cycle. Clear wins over halt, halt wins over count.
 */
`timescale 1ns/1ns
`default_nettype none

`include "rtc_consts.svh"

module rtc_tick_gen (
	input  logic rtc_clk,
	input  logic rst_n,
	input  logic fast_sim_time,   // Tick from divider bit 0
	input  logic cfg_rtc_update,
	input  logic cfg_rtc_halt,
	input  logic cfg_rtc_reset,
	output logic second_tick
);

	logic [`RTC_DIV_WIDTH-1:0] rtc_div;   // Free running divider
	logic                      tick_r;    // Divider overflow, registered

	//------------------------------
	// Divider and overflow tick
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			rtc_div <= '0;
			tick_r  <= 1'b0;
		end else if (cfg_rtc_update || cfg_rtc_reset) begin
			rtc_div <= '0;   // Restart the second on every load
			tick_r  <= 1'b0;
		end else if (cfg_rtc_halt) begin
			tick_r  <= 1'b0; // Divider frozen
		end else begin
			rtc_div <= rtc_div + 1'b1;
			tick_r  <= &rtc_div;   // High the cycle after all ones
		end
	end

	// Fast mode: every other cycle, still stopped by halt
	assign second_tick = fast_sim_time ? (rtc_div[0] & ~cfg_rtc_halt) : tick_r;

	// Overflow tick lasts exactly one cycle
	a_tick_pulse: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		tick_r |=> !tick_r);

endmodule

`default_nettype wire

// File: source/rtc_time_counter.sv
/*
 * Stage two of the RTC pipeline.
 * BCD seconds, minutes, hours (24-hour) and day of week, advanced by
 * second_tick. day_tick leaves combinationally at 23:59:59.
 */
`timescale 1ns/1ns
`default_nettype none

`include "rtc_consts.svh"

module rtc_time_counter (
	input  logic               rtc_clk,
	input  logic               rst_n,
	input  logic               cfg_rtc_update,   // Load from cfg_time
	input  logic               second_tick,
	input  rtc_pkg::cfg_word_t cfg_time,
	output rtc_pkg::bcd_digit_t time_s,
	output rtc_pkg::bcd_tens3_t time_ts,
	output rtc_pkg::bcd_digit_t time_m,
	output rtc_pkg::bcd_tens3_t time_tm,
	output rtc_pkg::bcd_digit_t time_h,
	output rtc_pkg::bcd_tens2_t time_th,
	output rtc_pkg::dow_t       time_dow,
	output logic               day_tick      // To the date stage
);

	import rtc_pkg::*;

	//------------------------------
	// Carry chain
	//------------------------------
	logic s_wrap;    // x9 -> next ten seconds
	logic ts_wrap;   // 59 s -> next minute
	logic m_wrap;
	logic tm_wrap;   // 59:59 -> next hour
	logic h_wrap;    // Units of hour back to 0

	assign s_wrap   = second_tick & (time_s == 4'd9);
	assign ts_wrap  = s_wrap & (time_ts == 3'd5);
	assign m_wrap   = ts_wrap & (time_m == 4'd9);
	assign tm_wrap  = m_wrap & (time_tm == 3'd5);
	assign day_tick = tm_wrap & (time_th == 2'd2) & (time_h == 4'd3);   // 23:59:59
	assign h_wrap   = day_tick | (tm_wrap & (time_h == 4'd9));

	//------------------------------
	// Seconds
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			time_s  <= '0;
			time_ts <= '0;
		end else if (cfg_rtc_update) begin
			time_s  <= cfg_time[0 +: $bits(bcd_digit_t)];
			time_ts <= cfg_time[4 +: $bits(bcd_tens3_t)];
		end else if (second_tick) begin
			time_s  <= s_wrap ? 4'd0 : time_s + 4'd1;
			if (s_wrap)
				time_ts <= ts_wrap ? 3'd0 : time_ts + 3'd1;
		end
	end

	//------------------------------
	// Minutes
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			time_m  <= '0;
			time_tm <= '0;
		end else if (cfg_rtc_update) begin
			time_m  <= cfg_time[`RTC_CFG_MIN_LSB +: $bits(bcd_digit_t)];
			time_tm <= cfg_time[`RTC_CFG_MIN_LSB + 4 +: $bits(bcd_tens3_t)];
		end else if (ts_wrap) begin
			time_m  <= m_wrap ? 4'd0 : time_m + 4'd1;
			if (m_wrap)
				time_tm <= tm_wrap ? 3'd0 : time_tm + 3'd1;
		end
	end

	//------------------------------
	// Hours and day of week
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			time_h   <= '0;
			time_th  <= '0;
			time_dow <= dow_t'(`RTC_DOW_MIN);
		end else if (cfg_rtc_update) begin
			time_h   <= cfg_time[`RTC_CFG_HOUR_LSB +: $bits(bcd_digit_t)];
			time_th  <= cfg_time[`RTC_CFG_HOUR_LSB + 4 +: $bits(bcd_tens2_t)];
			time_dow <= cfg_time[`RTC_CFG_DOW_LSB +: $bits(dow_t)];
		end else if (tm_wrap) begin
			time_h <= h_wrap ? 4'd0 : time_h + 4'd1;
			if (day_tick) begin
				time_th  <= 2'd0;   // 23 -> 00
				time_dow <= (time_dow == dow_t'(`RTC_DOW_MAX)) ?
					dow_t'(`RTC_DOW_MIN) : time_dow + 3'd1;
			end else if (h_wrap) begin
				time_th <= time_th + 2'd1;   // 09 -> 10, 19 -> 20
			end
		end
	end

	a_units_bcd: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		(time_s <= 4'd9) && (time_m <= 4'd9) && (time_h <= 4'd9));

	// 24-hour range, 00..23
	a_hour_range: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		(time_th < 2'd2) || ((time_th == 2'd2) && (time_h <= 4'd3)));

endmodule

`default_nettype wire

// File: source/rtc_date_counter.sv
/*
 * Stage three of the RTC pipeline.
 * BCD day, month, year and century, advanced by day_tick from the time
 * stage. Month length and Gregorian leap years come from the digits.
 */
`timescale 1ns/1ns
`default_nettype none

`include "rtc_consts.svh"

module rtc_date_counter (
	input  logic               rtc_clk,
	input  logic               rst_n,
	input  logic               cfg_rtc_update,   // Load from cfg_date
	input  logic               day_tick,
	input  rtc_pkg::cfg_word_t cfg_date,
	output rtc_pkg::bcd_digit_t date_d,
	output rtc_pkg::bcd_tens2_t date_td,
	output rtc_pkg::bcd_digit_t date_m,
	output logic               date_tm,
	output rtc_pkg::bcd_digit_t date_y,
	output rtc_pkg::bcd_digit_t date_ty,
	output rtc_pkg::bcd_digit_t date_c,
	output rtc_pkg::bcd_digit_t date_tc
);

	import rtc_pkg::*;

	// Two BCD digits divisible by 4: 10t + u = 2t + u (mod 4)
	function automatic logic bcd_div4(input bcd_digit_t tens, input bcd_digit_t units);
		bcd_div4 = tens[0] ? (units[1:0] == 2'b10) : (units[1:0] == 2'b00);
	endfunction

	//------------------------------
	// Leap year and month length
	//------------------------------
	logic       year_zero;   // xx00, century decides
	logic       leapyear;
	logic       is_feb;
	logic       is_short;    // Apr, Jun, Sep, Nov
	bcd_digit_t last_d;      // Units of the month's last day
	logic       day_last;

	assign year_zero = (date_ty == 4'd0) && (date_y == 4'd0);
	assign leapyear  = year_zero ? bcd_div4(date_tc, date_c) : bcd_div4(date_ty, date_y);

	assign is_feb   = !date_tm && (date_m == 4'd2);
	assign is_short = (!date_tm && ((date_m == 4'd4) || (date_m == 4'd6) || (date_m == 4'd9)))
		|| (date_tm && (date_m == 4'd1));

	always_comb begin
		if (is_feb)
			last_d = leapyear ? 4'd9 : 4'd8;   // 29 or 28
		else if (is_short)
			last_d = 4'd0;                     // 30
		else
			last_d = 4'd1;                     // 31
	end

	// Feb ends in the 20s, every other month in the 30s
	assign day_last = (date_td == (is_feb ? 2'd2 : 2'd3)) && (date_d == last_d);

	//------------------------------
	// Carry chain
	//------------------------------
	logic month_inc;   // Day past month end
	logic year_inc;    // Dec -> Jan
	logic ty_inc;
	logic c_inc;       // 99 -> 00, next century
	logic tc_inc;

	assign month_inc = day_tick & day_last;
	assign year_inc  = month_inc & date_tm & (date_m == 4'd2);
	assign ty_inc    = year_inc & (date_y == 4'd9);
	assign c_inc     = ty_inc & (date_ty == 4'd9);
	assign tc_inc    = c_inc & (date_c == 4'd9);

	// Day
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			date_d  <= 4'd1;
			date_td <= '0;
		end else if (cfg_rtc_update) begin
			date_d  <= cfg_date[0 +: $bits(bcd_digit_t)];
			date_td <= cfg_date[4 +: $bits(bcd_tens2_t)];
		end else if (month_inc) begin
			date_d  <= 4'd1;   // Back to the 1st
			date_td <= 2'd0;
		end else if (day_tick) begin
			date_d <= (date_d == 4'd9) ? 4'd0 : date_d + 4'd1;
			if (date_d == 4'd9)
				date_td <= date_td + 2'd1;
		end
	end

	// Month
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			date_m  <= 4'd1;
			date_tm <= 1'b0;
		end else if (cfg_rtc_update) begin
			date_m  <= cfg_date[`RTC_CFG_MONTH_LSB +: $bits(bcd_digit_t)];
			date_tm <= cfg_date[`RTC_CFG_MONTH_LSB + 4];
		end else if (year_inc) begin
			date_m  <= 4'd1;   // 12 -> 01
			date_tm <= 1'b0;
		end else if (month_inc) begin
			date_m <= (date_m == 4'd9) ? 4'd0 : date_m + 4'd1;
			if (date_m == 4'd9)
				date_tm <= 1'b1;   // 09 -> 10
		end
	end

	// Year and century, plain decimal digits
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			date_y  <= '0;
			date_ty <= '0;
			date_c  <= '0;
			date_tc <= '0;
		end else if (cfg_rtc_update) begin
			date_y  <= cfg_date[`RTC_CFG_YEAR_LSB +: $bits(bcd_digit_t)];
			date_ty <= cfg_date[`RTC_CFG_YEAR_LSB + 4 +: $bits(bcd_digit_t)];
			date_c  <= cfg_date[`RTC_CFG_CENT_LSB +: $bits(bcd_digit_t)];
			date_tc <= cfg_date[`RTC_CFG_CENT_LSB + 4 +: $bits(bcd_digit_t)];
		end else begin
			if (year_inc)
				date_y <= ty_inc ? 4'd0 : date_y + 4'd1;
			if (ty_inc)
				date_ty <= c_inc ? 4'd0 : date_ty + 4'd1;
			if (c_inc)
				date_c <= tc_inc ? 4'd0 : date_c + 4'd1;
			if (tc_inc)
				date_tc <= (date_tc == 4'd9) ? 4'd0 : date_tc + 4'd1;
		end
	end

	a_day_month_nonzero: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		({date_td, date_d} != 6'd0) && ({date_tm, date_m} != 5'd0));

endmodule

`default_nettype wire

// File: source/rtc_core.sv
/*
 * RTC core top level.
 * Tick generator, time stage and date stage in a free-running pipeline.
 */
`timescale 1ns/1ns
`default_nettype none

module rtc_core (
	input  logic               rtc_clk,
	input  logic               rst_n,
	input  logic               fast_sim_time,
	input  logic               cfg_rtc_update,
	input  logic               cfg_rtc_halt,
	input  logic               cfg_rtc_reset,
	input  rtc_pkg::cfg_word_t cfg_time,
	input  rtc_pkg::cfg_word_t cfg_date,
	// Time
	output rtc_pkg::bcd_digit_t time_s,
	output rtc_pkg::bcd_tens3_t time_ts,
	output rtc_pkg::bcd_digit_t time_m,
	output rtc_pkg::bcd_tens3_t time_tm,
	output rtc_pkg::bcd_digit_t time_h,
	output rtc_pkg::bcd_tens2_t time_th,
	output rtc_pkg::dow_t       time_dow,
	// Date
	output rtc_pkg::bcd_digit_t date_d,
	output rtc_pkg::bcd_tens2_t date_td,
	output rtc_pkg::bcd_digit_t date_m,
	output logic               date_tm,
	output rtc_pkg::bcd_digit_t date_y,
	output rtc_pkg::bcd_digit_t date_ty,
	output rtc_pkg::bcd_digit_t date_c,
	output rtc_pkg::bcd_digit_t date_tc
);

	logic second_tick;   // Stage one to two, registered
	logic day_tick;      // Stage two to three, combinational

	rtc_tick_gen u_tick_gen (
		.rtc_clk, .rst_n, .fast_sim_time,
		.cfg_rtc_update, .cfg_rtc_halt, .cfg_rtc_reset,
		.second_tick
	);

	rtc_time_counter u_time (
		.rtc_clk, .rst_n, .cfg_rtc_update, .second_tick, .cfg_time,
		.time_s, .time_ts, .time_m, .time_tm, .time_h, .time_th, .time_dow,
		.day_tick
	);

	rtc_date_counter u_date (
		.rtc_clk, .rst_n, .cfg_rtc_update, .day_tick, .cfg_date,
		.date_d, .date_td, .date_m, .date_tm,
		.date_y, .date_ty, .date_c, .date_tc
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/*
 * Clock and reset source for the RTC testbench.
 * 20 ns rtc_clk, rst_n held low for the first 5 rising edges.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic rtc_clk,
	output logic rst_n
);

	initial begin
		rtc_clk = 1'b0;
		forever #10 rtc_clk = ~rtc_clk;   // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge rtc_clk);
		rst_n <= 1'b1;   // Released on an edge
	end

endmodule

`default_nettype wire

// File: testbench/rtc_core_tb.sv
/*
 * Directed testbench for the RTC core.
 * Loads time and date words, runs fast and normal ticks and compares the
 * BCD outputs with values worked out from the calendar rules.
 */
`timescale 1ns/1ns
`default_nettype none

module rtc_core_tb;

	import rtc_pkg::*;

	localparam int CYCLE_LIMIT = 40000;   // One normal second plus the fast tests

	logic       rtc_clk;
	logic       rst_n;
	logic       fast_sim_time;
	logic       cfg_rtc_update;
	logic       cfg_rtc_halt;
	logic       cfg_rtc_reset;
	cfg_word_t  cfg_time;
	cfg_word_t  cfg_date;
	bcd_digit_t time_s, time_m, time_h;
	bcd_tens3_t time_ts, time_tm;
	bcd_tens2_t time_th, date_td;
	dow_t       time_dow;
	bcd_digit_t date_d, date_m, date_y, date_ty, date_c, date_tc;
	logic       date_tm;
	int         cycles = 0;

	tb_clock_gen clk_gen (.rtc_clk, .rst_n);

	rtc_core dut0 (.*);

	//------------------------------
	// Calendar reference
	//------------------------------
	function automatic logic [7:0] to_bcd(input int value);
		return {4'(value / 10), 4'(value % 10)};   // Two packed digits
	endfunction

	// Gregorian rule on the four-digit year
	function automatic bit leap_year(input int year);
		return (year % 4 == 0) && ((year % 100 != 0) || (year % 400 == 0));
	endfunction

	function automatic int month_days(input int year, input int month);
		case (month)
			2: return leap_year(year) ? 29 : 28;
			4, 6, 9, 11: return 30;
			default: return 31;
		endcase
	endfunction

	//------------------------------
	// Compare tasks
	//------------------------------
	task automatic check_digit(input string name, input bcd_digit_t expected,
			input bcd_digit_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_tens3(input string name, input bcd_tens3_t expected,
			input bcd_tens3_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_tens2(input string name, input bcd_tens2_t expected,
			input bcd_tens2_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_dow(input string name, input dow_t expected, input dow_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_time(input string name, input int h, input int m, input int s,
			input int dow);
		check_digit({name, " sec"}, bcd_digit_t'(s % 10), time_s);
		check_tens3({name, " sec"}, bcd_tens3_t'(s / 10), time_ts);
		check_digit({name, " min"}, bcd_digit_t'(m % 10), time_m);
		check_tens3({name, " min"}, bcd_tens3_t'(m / 10), time_tm);
		check_digit({name, " hour"}, bcd_digit_t'(h % 10), time_h);
		check_tens2({name, " hour"}, bcd_tens2_t'(h / 10), time_th);
		check_dow({name, " dow"}, dow_t'(dow), time_dow);
	endtask

	task automatic check_date(input string name, input int year4, input int month,
			input int day);
		check_digit({name, " day"}, bcd_digit_t'(day % 10), date_d);
		check_tens2({name, " day"}, bcd_tens2_t'(day / 10), date_td);
		check_digit({name, " month"}, bcd_digit_t'(month % 10), date_m);
		check_digit({name, " month"}, bcd_digit_t'(month / 10), {3'b000, date_tm});
		check_digit({name, " year"}, bcd_digit_t'(year4 % 10), date_y);
		check_digit({name, " year"}, bcd_digit_t'((year4 / 10) % 10), date_ty);
		check_digit({name, " century"}, bcd_digit_t'((year4 / 100) % 10), date_c);
		check_digit({name, " century"}, bcd_digit_t'(year4 / 1000), date_tc);
	endtask

	// Load edge is the second rising edge; returns right after it
	task automatic load_config(input int h, input int m, input int s, input int dow,
			input int year4, input int month, input int day);
		@(posedge rtc_clk);
		cfg_time       <= {8'(dow), to_bcd(h), to_bcd(m), to_bcd(s)};
		cfg_date       <= {to_bcd(year4 / 100), to_bcd(year4 % 100), to_bcd(month), to_bcd(day)};
		cfg_rtc_update <= 1'b1;
		@(posedge rtc_clk);
		cfg_rtc_update <= 1'b0;
	endtask

	//------------------------------
	// Directed tests
	//------------------------------
	task automatic reset_values();
		@(negedge rtc_clk);
		check_time("reset", 0, 0, 0, 1);
		check_date("reset", 0, 1, 1);
	endtask

	// One fast tick every 2 cycles after the load
	task automatic fast_count();
		int h;
		int m;
		int s;
		int n;
		h = $urandom_range(23);
		m = $urandom_range(59);
		s = $urandom_range(49);   // No minute carry
		n = $urandom_range(9, 1);
		load_config(h, m, s, 3, 2024, 6, 15);
		repeat (2 * n) @(posedge rtc_clk);
		@(negedge rtc_clk);
		check_time("fast_count", h, m, s + n, 3);
		check_date("fast_count", 2024, 6, 15);
	endtask

	task automatic day_rollover(input string name, input int year4, input int month,
			input int day);
		int next_day;
		int next_month;
		int next_year;
		next_day   = day + 1;
		next_month = month;
		next_year  = year4;
		if (next_day > month_days(year4, month)) begin
			next_day   = 1;
			next_month = month + 1;
			if (next_month > 12) begin
				next_month = 1;
				next_year  = (year4 + 1) % 10000;
			end
		end
		load_config(23, 59, 59, 7, year4, month, day);
		repeat (2) @(posedge rtc_clk);   // One fast tick
		@(negedge rtc_clk);
		check_time(name, 0, 0, 0, 1);
		check_date(name, next_year, next_month, next_day);
	endtask

	// Two fast ticks land before halt takes effect
	task automatic halt_hold();
		load_config(12, 34, 0, 2, 2024, 3, 9);
		repeat (5) @(posedge rtc_clk);
		cfg_rtc_halt <= 1'b1;
		repeat (50) begin
			@(posedge rtc_clk);
			@(negedge rtc_clk);
			check_time("halt", 12, 34, 2, 2);
			check_date("halt", 2024, 3, 9);
		end
		@(posedge rtc_clk);
		cfg_rtc_halt <= 1'b0;
	endtask

	// Divider held clear, first fast tick two edges after release
	task automatic divider_clear();
		load_config(6, 0, 10, 5, 2024, 1, 1);
		cfg_rtc_reset <= 1'b1;
		repeat (10) begin
			@(posedge rtc_clk);
			@(negedge rtc_clk);
			check_time("divider reset", 6, 0, 10, 5);
		end
		@(posedge rtc_clk);
		cfg_rtc_reset <= 1'b0;
		repeat (2) @(posedge rtc_clk);
		@(negedge rtc_clk);
		check_time("divider release", 6, 0, 11, 5);
	endtask

	// Tick rises 2^15 cycles after the load, seconds follow one edge later
	task automatic normal_second();
		@(posedge rtc_clk);
		fast_sim_time <= 1'b0;
		load_config(8, 15, 30, 4, 2024, 7, 1);
		repeat (32768) begin
			@(posedge rtc_clk);
			@(negedge rtc_clk);
			check_digit("normal early", 4'd0, time_s);
		end
		@(posedge rtc_clk);
		@(negedge rtc_clk);
		check_time("normal second", 8, 15, 31, 4);
	endtask

	// Hang guard
	always @(posedge rtc_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no verdict after %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	initial begin
		void'($urandom(32'hd535));
		fast_sim_time  = 1'b1;
		cfg_rtc_update = 1'b0;
		cfg_rtc_halt   = 1'b0;
		cfg_rtc_reset  = 1'b0;
		cfg_time       = '0;
		cfg_date       = '0;
		wait (rst_n === 1'b1);
		reset_values();
		fast_count();
		day_rollover("feb 2023", 2023, 2, 28);
		day_rollover("feb 2024", 2024, 2, 28);
		day_rollover("feb 1900", 1900, 2, 28);
		day_rollover("feb 2000", 2000, 2, 28);
		day_rollover("dec 2099", 2099, 12, 31);
		day_rollover("apr 30", 2024, 4, 30);
		halt_hold();
		divider_clear();
		normal_second();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtc_core.f
+incdir+source
source/rtc_pkg.sv
source/rtc_tick_gen.sv
source/rtc_time_counter.sv
source/rtc_date_counter.sv
source/rtc_core.sv
testbench/tb_clock_gen.sv
testbench/rtc_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RTC core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f rtc_core.f --top-module rtc_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vrtc_core_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation binary returned an error"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation passed$"; then
	exit 0
fi
exit 1
